// ==== sources.f ====
+incdir+include
hdl/redmule_pkg.sv
hdl/redmule_regfile.sv
hdl/redmule_scheduler.sv
hdl/redmule_row.sv
hdl/redmule_z_collector.sv
hdl/redmule_top.sv
verif/redmule_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := redmule_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := TEST OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== include/redmule_tb_tasks.svh ====
`ifndef REDMULE_TB_TASKS_SVH
`define REDMULE_TB_TASKS_SVH

// Byte address of element [r][c] in a row-major matrix window
function automatic logic [WB_AW-1:0] elem_addr(input logic [WB_AW-1:0] base, input int r,
                                               input int c);
  return base + WB_AW'(4 * (ARRAY_N * r + c));
endfunction

// One classic cycle, held through the edge after ack so a write commits
task automatic bus_access(input logic we, input logic [WB_AW-1:0] addr,
                          input logic [WB_DW-1:0] wdata, output logic [WB_DW-1:0] rdata);
  wb_req.cyc = 1'b1;
  wb_req.stb = 1'b1;
  wb_req.we  = we;
  wb_req.adr = addr;
  wb_req.dat = wdata;
  wb_req.sel = '1;
  @(negedge clk);
  while (!wb_ack) @(negedge clk);
  rdata = wb_rdata;
  @(negedge clk);
  wb_req = '0;
endtask

task automatic wb_write(input logic [WB_AW-1:0] addr, input logic [WB_DW-1:0] data);
  logic [WB_DW-1:0] unused;
  bus_access(1'b1, addr, data, unused);
endtask

task automatic wb_read(input logic [WB_AW-1:0] addr, output logic [WB_DW-1:0] data);
  bus_access(1'b0, addr, '0, data);
endtask

task automatic check_eq(input string name, input logic [WB_DW-1:0] got,
                        input logic [WB_DW-1:0] exp);
  assert (got === exp) else begin
    $display("Error: %s = %h, expected %h", name, got, exp);
    err_cnt++;
  end
endtask

task automatic begin_test();
  test_err_base = err_cnt;
endtask

task automatic end_test(input string name);
  int errs;
  errs = err_cnt - test_err_base;
  n_tests++;
  if (errs == 0) begin
    $display("%s: passed", name);
  end else begin
    n_failed++;
    $display("%s: failed with %0d errors", name, errs);
  end
endtask

// X and W words carry pad in their upper half, which the DUT drops
task automatic load_operands(input x_mat_t x, input w_mat_t w, input acc_mat_t y,
                             input logic [15:0] pad);
  for (int r = 0; r < ARRAY_H; r++) begin
    for (int c = 0; c < ARRAY_N; c++) begin
      wb_write(elem_addr(BASE_X, r, c), {pad, x[r][c]});
      wb_write(elem_addr(BASE_W, r, c), {pad, w[r][c]});
      wb_write(elem_addr(BASE_Y, r, c), y[r][c]);
    end
  end
endtask

task automatic random_operands(output x_mat_t x, output w_mat_t w, output acc_mat_t y);
  for (int r = 0; r < ARRAY_H; r++) begin
    for (int c = 0; c < ARRAY_N; c++) begin
      x[r][c] = 16'($random(seed));
      w[r][c] = 16'($random(seed));
      y[r][c] = 32'($random(seed));
    end
  end
endtask

task automatic start_job(input op_e op);
  wb_write(REG_CTRL, {{(WB_DW-2){1'b0}}, op, 1'b1});
endtask

// done_o may already be high when a busy-time access returns
task automatic wait_done();
  int n;
  n = 0;
  while (!done && n < DONE_WAIT_CYCLES) begin
    @(negedge clk);
    n++;
  end
  assert (done) else begin
    $display("done_o did not pulse within %0d cycles of the start", DONE_WAIT_CYCLES);
    err_cnt++;
  end
endtask

task automatic check_z(input acc_mat_t exp_z);
  logic [WB_DW-1:0] rdata;
  for (int r = 0; r < ARRAY_H; r++) begin
    for (int c = 0; c < ARRAY_N; c++) begin
      wb_read(elem_addr(BASE_Z, r, c), rdata);
      check_eq($sformatf("Z[%0d][%0d]", r, c), rdata, exp_z[r][c]);
    end
  end
endtask

task automatic check_reset_state();
  logic [WB_DW-1:0] rdata;
  acc_mat_t         zero_z;
  begin_test();
  zero_z = '0;
  check_eq("busy_o", 32'(busy), 32'h0);
  check_eq("done_o", 32'(done), 32'h0);
  wb_read(REG_STATUS, rdata);
  check_eq("STATUS", rdata, 32'h0);
  // Anti-diagonal sample of X
  for (int r = 0; r < ARRAY_H; r++) begin
    wb_read(elem_addr(BASE_X, r, ARRAY_K - 1 - r), rdata);
    check_eq($sformatf("X[%0d][%0d]", r, ARRAY_K - 1 - r), rdata, 32'h0);
  end
  check_z(zero_z);
  end_test("reset state");
endtask

task automatic run_mac_identity();
  x_mat_t   x;
  w_mat_t   w;
  acc_mat_t y;
  acc_mat_t exp_z;
  begin_test();
  for (int r = 0; r < ARRAY_H; r++) begin
    for (int c = 0; c < ARRAY_N; c++) begin
      x[r][c]     = (r == c) ? 16'd1 : 16'd0;
      w[r][c]     = 16'(ARRAY_N * r + c + 1);
      y[r][c]     = 32'(1000 * (r + 1) + 10 * c);
      exp_z[r][c] = {{(ACC_W-ELEM_W){w[r][c][ELEM_W-1]}}, w[r][c]} + y[r][c];
    end
  end
  load_operands(x, w, y, 16'h0000);
  start_job(OP_MAC);
  wait_done();
  check_z(exp_z);
  end_test("MAC with identity X");
endtask

task automatic run_mul_random();
  x_mat_t   x;
  w_mat_t   w;
  acc_mat_t y;
  begin_test();
  random_operands(x, w, y);
  load_operands(x, w, y, 16'hc3a5);
  start_job(OP_MUL);
  wait_done();
  check_z(model_z(x, w, y, OP_MUL));
  end_test("MUL random");
endtask

task automatic run_mac_random();
  x_mat_t           x;
  w_mat_t           w;
  acc_mat_t         y;
  logic [WB_DW-1:0] rdata;
  begin_test();
  random_operands(x, w, y);
  load_operands(x, w, y, 16'h0000);
  start_job(OP_MAC);
  wait_done();
  check_z(model_z(x, w, y, OP_MAC));
  wb_read(REG_STATUS, rdata);
  check_eq("STATUS", rdata, 32'h2);
  end_test("MAC random");
endtask

task automatic run_busy_writes();
  x_mat_t           x;
  w_mat_t           w;
  acc_mat_t         y;
  logic [WB_DW-1:0] rdata;
  begin_test();
  random_operands(x, w, y);
  load_operands(x, w, y, 16'h0000);
  start_job(OP_MAC);
  check_eq("busy_o", 32'(busy), 32'h1);
  // The last reduction step has not been fed yet when this write would commit
  wb_write(elem_addr(BASE_X, 0, ARRAY_K - 1), 32'(~x[0][ARRAY_K-1]));
  wb_write(elem_addr(BASE_X, 1, 1), 32'(~x[1][1]));
  check_eq("busy_o", 32'(busy), 32'h1);
  // Second start lands while the first job drains
  start_job(OP_MUL);
  wait_done();
  check_z(model_z(x, w, y, OP_MAC));
  wb_read(elem_addr(BASE_X, 0, ARRAY_K - 1), rdata);
  check_eq("X[0][3]", rdata, 32'(x[0][ARRAY_K-1]));
  wb_read(REG_CTRL, rdata);
  check_eq("CTRL", rdata, 32'h0);
  wb_read(REG_STATUS, rdata);
  check_eq("STATUS", rdata, 32'h2);
  start_job(OP_MUL);
  wb_read(REG_STATUS, rdata);
  check_eq("STATUS", rdata, 32'h1);
  wait_done();
  check_z(model_z(x, w, y, OP_MUL));
  end_test("writes while busy");
endtask

`endif

// ==== verif/redmule_tb.sv ====
module redmule_tb
  import redmule_pkg::*;
();

  // Roughly three times the 660 cycles that the five tests take
  localparam int TIMEOUT_CYCLES   = 2000;
  localparam int DONE_WAIT_CYCLES = 64;

  logic             clk;
  logic             rst_n;
  wb_req_t          wb_req;
  logic [WB_DW-1:0] wb_rdata;
  logic             wb_ack;
  logic             busy;
  logic             done;

  integer seed;
  int     cycle_cnt;
  int     err_cnt;
  int     test_err_base;
  int     n_tests;
  int     n_failed;

  redmule_top i_dut (
    .clk_i    ( clk      ),
    .rst_n_i  ( rst_n    ),
    .wb_i     ( wb_req   ),
    .wb_dat_o ( wb_rdata ),
    .wb_ack_o ( wb_ack   ),
    .busy_o   ( busy     ),
    .done_o   ( done     )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reference Z from sign-extended 16-bit products with 32-bit wrapping sums and bias only for MAC
  function automatic acc_mat_t model_z(input x_mat_t x, input w_mat_t w, input acc_mat_t y,
                                       input op_e op);
    acc_mat_t         z;
    logic [ACC_W-1:0] xext;
    logic [ACC_W-1:0] wext;
    for (int r = 0; r < ARRAY_H; r++) begin
      for (int c = 0; c < ARRAY_N; c++) begin
        z[r][c] = (op == OP_MAC) ? y[r][c] : '0;
        for (int k = 0; k < ARRAY_K; k++) begin
          xext = {{(ACC_W-ELEM_W){x[r][k][ELEM_W-1]}}, x[r][k]};
          wext = {{(ACC_W-ELEM_W){w[k][c][ELEM_W-1]}}, w[k][c]};
          z[r][c] = z[r][c] + xext * wext;
        end
      end
    end
    return z;
  endfunction

  `include "redmule_tb_tasks.svh"

  // Watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run was still going after %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    seed          = 32'hd2ff_0fb2;
    err_cnt       = 0;
    test_err_base = 0;
    n_tests       = 0;
    n_failed      = 0;
    wb_req        = '0;
    rst_n         = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    check_reset_state();
    run_mac_identity();
    run_mul_random();
    run_mac_random();
    run_busy_writes();

    $display("Tests run %0d, tests failed %0d, errors %0d", n_tests, n_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : redmule_tb

// ==== hdl/redmule_top.sv ====
module redmule_top
  import redmule_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  wb_req_t          wb_i,
  output logic [WB_DW-1:0] wb_dat_o,
  output logic             wb_ack_o,
  output logic             busy_o,
  output logic             done_o
);

  logic                        start;
  op_e                         op;
  x_mat_t                      x_mat;
  w_mat_t                      w_mat;
  acc_mat_t                    y_mat;
  acc_mat_t                    z_mat;
  row_feed_t   [ARRAY_H-1:0]   feed;
  row_result_t [ARRAY_H-1:0]   results;

  // Bus-side control and operand storage
  redmule_regfile i_regfile (
    .clk_i    ( clk_i    ),
    .rst_n_i  ( rst_n_i  ),
    .wb_i     ( wb_i     ),
    .wb_dat_o ( wb_dat_o ),
    .wb_ack_o ( wb_ack_o ),
    .busy_i   ( busy_o   ),
    .done_i   ( done_o   ),
    .z_i      ( z_mat    ),
    .start_o  ( start    ),
    .op_o     ( op       ),
    .x_o      ( x_mat    ),
    .w_o      ( w_mat    ),
    .y_o      ( y_mat    )
  );

  redmule_scheduler i_scheduler (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .start_i ( start   ),
    .op_i    ( op      ),
    .x_i     ( x_mat   ),
    .w_i     ( w_mat   ),
    .y_i     ( y_mat   ),
    .done_i  ( done_o  ),
    .busy_o  ( busy_o  ),
    .feed_o  ( feed    )
  );

  // One processing row per row of Z
  for (genvar r = 0; r < ARRAY_H; r++) begin : gen_rows
    redmule_row i_row (
      .clk_i    ( clk_i      ),
      .rst_n_i  ( rst_n_i    ),
      .feed_i   ( feed[r]    ),
      .result_o ( results[r] )
    );
  end

  redmule_z_collector i_z_collector (
    .clk_i     ( clk_i   ),
    .rst_n_i   ( rst_n_i ),
    .results_i ( results ),
    .z_o       ( z_mat   ),
    .done_o    ( done_o  )
  );

endmodule : redmule_top

// ==== hdl/redmule_z_collector.sv ====
module redmule_z_collector
  import redmule_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  row_result_t [ARRAY_H-1:0]   results_i,
  output acc_mat_t                    z_o,
  output logic                        done_o
);

  acc_mat_t z_q;
  logic     done_q;
  logic     all_valid;

  // Rows run in lockstep, so all results land together
  always_comb begin
    all_valid = 1'b1;
    for (int r = 0; r < ARRAY_H; r++) begin
      all_valid = all_valid & results_i[r].valid;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      z_q    <= '0;
      done_q <= 1'b0;
    end else begin
      for (int r = 0; r < ARRAY_H; r++) begin
        if (results_i[r].valid) begin
          z_q[r] <= results_i[r].acc;
        end
      end
      done_q <= all_valid;
    end
  end

  assign z_o    = z_q;
  assign done_o = done_q;

endmodule : redmule_z_collector

// ==== hdl/redmule_row.sv ====
module redmule_row
  import redmule_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  row_feed_t   feed_i,
  output row_result_t result_o
);

  acc_row_t prod;
  acc_row_t prod_q;
  acc_row_t bias_q;
  acc_row_t acc_q;
  logic     s1_valid_q;
  logic     s1_first_q;
  logic     s1_last_q;
  logic     res_valid_q;

  // Sign-extended products, wrapping at 32 bits
  always_comb begin
    for (int c = 0; c < ARRAY_N; c++) begin
      prod[c] = ACC_W'(signed'(feed_i.x)) * ACC_W'(signed'(feed_i.w[c]));
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid_q  <= 1'b0;
      s1_first_q  <= 1'b0;
      s1_last_q   <= 1'b0;
      res_valid_q <= 1'b0;
    end else begin
      s1_valid_q  <= feed_i.valid;
      s1_first_q  <= feed_i.first;
      s1_last_q   <= feed_i.last;
      res_valid_q <= s1_valid_q & s1_last_q;
    end
  end

  // Stage one payload
  always_ff @(posedge clk_i) begin
    if (feed_i.valid) begin
      prod_q <= prod;
      bias_q <= feed_i.bias;
    end
  end

  // Stage two, first step restarts from the bias
  always_ff @(posedge clk_i) begin
    if (s1_valid_q) begin
      for (int c = 0; c < ARRAY_N; c++) begin
        acc_q[c] <= (s1_first_q ? bias_q[c] : acc_q[c]) + prod_q[c];
      end
    end
  end

  assign result_o.valid = res_valid_q;
  assign result_o.acc   = acc_q;

endmodule : redmule_row

// ==== hdl/redmule_scheduler.sv ====
module redmule_scheduler
  import redmule_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        start_i,
  input  op_e                         op_i,
  input  x_mat_t                      x_i,
  input  w_mat_t                      w_i,
  input  acc_mat_t                    y_i,
  input  logic                        done_i,
  output logic                        busy_o,
  output row_feed_t [ARRAY_H-1:0]     feed_o
);

  sched_state_e      state_q;
  sched_state_e      state_d;
  logic [STEP_W-1:0] k_q;
  logic              first_step;
  logic              last_step;

  assign first_step = k_q == '0;
  assign last_step  = k_q == STEP_W'(ARRAY_K - 1);

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:  if (start_i) state_d = S_FEED;
      S_FEED:  if (last_step) state_d = S_DRAIN;
      // Rows still have products in flight
      S_DRAIN: if (done_i) state_d = S_IDLE;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
      k_q     <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == S_FEED) begin
        k_q <= k_q + 1'b1;
      end else begin
        k_q <= '0;
      end
    end
  end

  // W row k goes to every row, X[r][k] to row r only
  always_comb begin
    for (int r = 0; r < ARRAY_H; r++) begin
      feed_o[r].valid = state_q == S_FEED;
      feed_o[r].first = first_step;
      feed_o[r].last  = last_step;
      feed_o[r].x     = x_i[r][k_q];
      feed_o[r].w     = w_i[k_q];
      if (first_step && op_i == OP_MAC) begin
        feed_o[r].bias = y_i[r];
      end else begin
        feed_o[r].bias = '0;
      end
    end
  end

  assign busy_o = state_q != S_IDLE;

endmodule : redmule_scheduler

// ==== hdl/redmule_regfile.sv ====
module redmule_regfile
  import redmule_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  wb_req_t          wb_i,
  output logic [WB_DW-1:0] wb_dat_o,
  output logic             wb_ack_o,
  input  logic             busy_i,
  input  logic             done_i,
  input  acc_mat_t         z_i,
  output logic             start_o,
  output op_e              op_o,
  output x_mat_t           x_o,
  output w_mat_t           w_o,
  output acc_mat_t         y_o
);

  logic                          ack_q;
  logic                          done_q;
  op_e                           op_q;
  x_mat_t                        x_q;
  w_mat_t                        w_q;
  acc_mat_t                      y_q;
  logic                          wr_en;
  logic                          ctrl_hit;
  logic                          status_hit;
  logic                          ctrl_wr;
  logic [WB_AW-MAT_OFS_W-1:0]    region;
  logic [$clog2(ARRAY_H)-1:0]    row_idx;
  logic [$clog2(ARRAY_N)-1:0]    col_idx;
  logic [WB_DW-1:0]              wmask;
  logic [WB_DW-1:0]              rdata;

  // Row-major element index inside a matrix window
  assign region  = wb_i.adr[WB_AW-1:MAT_OFS_W];
  assign row_idx = wb_i.adr[5:4];
  assign col_idx = wb_i.adr[3:2];

  assign ctrl_hit   = wb_i.adr[WB_AW-1:2] == REG_CTRL[WB_AW-1:2];
  assign status_hit = wb_i.adr[WB_AW-1:2] == REG_STATUS[WB_AW-1:2];

  // Writes commit at the edge that closes the ack cycle
  assign wr_en   = ack_q & wb_i.cyc & wb_i.stb & wb_i.we;
  assign ctrl_wr = wr_en & ctrl_hit & wb_i.sel[0] & ~busy_i;
  assign start_o = ctrl_wr & wb_i.dat[0];

  always_comb begin
    for (int b = 0; b < WB_SW; b++) begin
      wmask[8*b +: 8] = {8{wb_i.sel[b]}};
    end
  end

  // Single-cycle ack, never back to back
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= wb_i.cyc & wb_i.stb & ~ack_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      op_q   <= OP_MAC;
      done_q <= 1'b0;
    end else begin
      if (ctrl_wr) begin
        op_q <= op_e'(wb_i.dat[1]);
      end
      // A new job clears the sticky flag
      if (start_o) begin
        done_q <= 1'b0;
      end else if (done_i) begin
        done_q <= 1'b1;
      end
    end
  end

  // Operand writes are dropped while a job runs
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      x_q <= '0;
      w_q <= '0;
      y_q <= '0;
    end else if (wr_en && !busy_i) begin
      case (region)
        BASE_X[WB_AW-1:MAT_OFS_W]: begin
          x_q[row_idx][col_idx] <= (x_q[row_idx][col_idx] & ~wmask[ELEM_W-1:0]) |
                                   (wb_i.dat[ELEM_W-1:0] & wmask[ELEM_W-1:0]);
        end
        BASE_W[WB_AW-1:MAT_OFS_W]: begin
          w_q[row_idx][col_idx] <= (w_q[row_idx][col_idx] & ~wmask[ELEM_W-1:0]) |
                                   (wb_i.dat[ELEM_W-1:0] & wmask[ELEM_W-1:0]);
        end
        BASE_Y[WB_AW-1:MAT_OFS_W]: begin
          y_q[row_idx][col_idx] <= (y_q[row_idx][col_idx] & ~wmask) | (wb_i.dat & wmask);
        end
        default: ;
      endcase
    end
  end

  // Read mux, unmapped words return zero
  always_comb begin
    rdata = '0;
    case (region)
      REG_CTRL[WB_AW-1:MAT_OFS_W]: begin
        if (ctrl_hit) begin
          rdata[1] = op_q == OP_MUL;
        end else if (status_hit) begin
          rdata[0] = busy_i;
          rdata[1] = done_q;
        end
      end
      BASE_X[WB_AW-1:MAT_OFS_W]: rdata[ELEM_W-1:0] = x_q[row_idx][col_idx];
      BASE_W[WB_AW-1:MAT_OFS_W]: rdata[ELEM_W-1:0] = w_q[row_idx][col_idx];
      BASE_Y[WB_AW-1:MAT_OFS_W]: rdata = y_q[row_idx][col_idx];
      BASE_Z[WB_AW-1:MAT_OFS_W]: rdata = z_i[row_idx][col_idx];
      default: ;
    endcase
  end

  assign wb_dat_o = rdata;
  assign wb_ack_o = ack_q;
  assign op_o     = op_q;
  assign x_o      = x_q;
  assign w_o      = w_q;
  assign y_o      = y_q;

endmodule : redmule_regfile

// ==== hdl/redmule_pkg.sv ====
package redmule_pkg;

  // Array geometry, fixed for this accelerator
  localparam int unsigned ARRAY_H = 4;
  localparam int unsigned ARRAY_K = 4;
  localparam int unsigned ARRAY_N = 4;

  // Datapath widths
  localparam int unsigned ELEM_W = 16;
  localparam int unsigned ACC_W  = 32;
  localparam int unsigned STEP_W = $clog2(ARRAY_K);

  // Wishbone port
  localparam int unsigned WB_DW  = 32;
  localparam int unsigned WB_AW  = 10;
  localparam int unsigned WB_SW  = WB_DW / 8;

  // Each matrix spans 16 words, so 6 byte-address bits select within it
  localparam int unsigned MAT_OFS_W = 6;

  // Register map, byte offsets
  localparam logic [WB_AW-1:0] REG_CTRL   = 10'h000;
  localparam logic [WB_AW-1:0] REG_STATUS = 10'h004;
  localparam logic [WB_AW-1:0] BASE_X     = 10'h040;
  localparam logic [WB_AW-1:0] BASE_W     = 10'h080;
  localparam logic [WB_AW-1:0] BASE_Y     = 10'h0C0;
  localparam logic [WB_AW-1:0] BASE_Z     = 10'h100;

  // CTRL bit 1 selects the operation
  typedef enum logic {
    OP_MAC = 1'b0,
    OP_MUL = 1'b1
  } op_e;

  typedef enum logic [1:0] {
    S_IDLE,
    S_FEED,
    S_DRAIN
  } sched_state_e;

  typedef logic [ARRAY_H-1:0][ARRAY_K-1:0][ELEM_W-1:0] x_mat_t;
  typedef logic [ARRAY_K-1:0][ARRAY_N-1:0][ELEM_W-1:0] w_mat_t;
  typedef logic [ARRAY_H-1:0][ARRAY_N-1:0][ACC_W-1:0]  acc_mat_t;
  typedef logic [ARRAY_N-1:0][ACC_W-1:0]               acc_row_t;
  typedef logic [ARRAY_N-1:0][ELEM_W-1:0]              w_row_t;

  // One reduction step for one processing row
  typedef struct packed {
    logic              valid;
    logic              first;
    logic              last;
    logic [ELEM_W-1:0] x;
    w_row_t            w;
    acc_row_t          bias;
  } row_feed_t;

  typedef struct packed {
    logic     valid;
    acc_row_t acc;
  } row_result_t;

  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [WB_AW-1:0] adr;
    logic [WB_DW-1:0] dat;
    logic [WB_SW-1:0] sel;
  } wb_req_t;

endpackage : redmule_pkg
